// ==== Bender.yml ====
package:
  name: rename_stage

sources:
  - files:
      - logic/rename_pkg.sv
      - logic/rename_req_if.sv
      - logic/slot_if.sv
      - logic/renamed_op_if.sv
      - logic/rename_intake.sv
      - logic/commit_slot_ring.sv
      - logic/rename_map.sv
      - logic/issue_credit.sv
      - logic/rename_stage.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/rename_stage_tb.sv

// ==== dv/rename_model.svh ====
/* reference model of the rename stage: map entries, commit slot ring, issue credits
   and the queue of accepted instructions still waiting to come out */

`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

logic map_pending [NUM_ARCH_REGS];
slot_t map_tag [NUM_ARCH_REGS];
int ring_head;
int ring_tail;
int ring_count;
int credit_count;
// accepted instructions in acceptance order
decoded_inst_t expect_queue [$];

function automatic void clear_state();
	for (int i = 0; i < NUM_ARCH_REGS; i++) begin
		map_pending[i] = 1'b0;
		map_tag[i] = '0;
	end
	ring_head = 0;
	ring_tail = 0;
	ring_count = 0;
	expect_queue.delete();
endfunction

// oldest slot leaves, its consumers fall back to the architectural register
function automatic void retire_oldest();
	if (ring_count == 0) begin
		return;
	end
	for (int i = 0; i < NUM_ARCH_REGS; i++) begin
		if (map_pending[i] && map_tag[i] == slot_t'(ring_head)) begin
			map_pending[i] = 1'b0;
		end
	end
	ring_head = (ring_head + 1) % NUM_SLOTS;
	ring_count--;
endfunction

function automatic operand_t lookup_source(arch_reg_t r);
	operand_t o;
	o.pending = 1'b0;
	o.tag = r;
	if (r != '0 && map_pending[r]) begin
		o.pending = 1'b1;
		o.tag = ARCH_REG_W'(map_tag[r]);
	end
	return o;
endfunction

// sources are read before the op's own destination takes a slot
function automatic renamed_op_t rename_next(decoded_inst_t inst);
	renamed_op_t op;
	op.rs1 = lookup_source(inst.rs1);
	op.rs2 = lookup_source(inst.rs2);
	op.rd_slot = slot_t'(ring_tail);
	op.rd_arch = inst.rd;
	op.makes_rd = inst.makes_rd;
	op.pc = inst.pc;
	if (inst.makes_rd && inst.rd != '0) begin
		map_pending[inst.rd] = 1'b1;
		map_tag[inst.rd] = slot_t'(ring_tail);
	end
	ring_tail = (ring_tail + 1) % NUM_SLOTS;
	ring_count++;
	credit_count--;
	return op;
endfunction

`endif

// ==== dv/rename_stage_tb.sv ====
/* testbench for the rename stage, random traffic checked against a reference model
   plus directed slot-full, credit-starved and flush phases */

`timescale 1ns/1ps

module rename_stage_tb;
	import rename_pkg::*;

	localparam time CLK_PERIOD = 40ns;
	localparam int NUM_INSTS = 600;
	localparam int SEED = 32'h4137;

	logic clk;
	logic reset;
	logic in_valid;
	logic [ARCH_REG_W-1:0] in_rs1;
	logic [ARCH_REG_W-1:0] in_rs2;
	logic [ARCH_REG_W-1:0] in_rd;
	logic in_makes_rd;
	logic [PC_W-1:0] in_pc;
	logic commit_valid;
	logic flush;
	logic credit_return;
	logic in_stall;
	logic out_valid;
	logic out_rs1_pending;
	logic [ARCH_REG_W-1:0] out_rs1_tag;
	logic out_rs2_pending;
	logic [ARCH_REG_W-1:0] out_rs2_tag;
	logic [SLOT_W-1:0] out_rd_slot;
	logic [ARCH_REG_W-1:0] out_rd_arch;
	logic out_makes_rd;
	logic [PC_W-1:0] out_pc;

	// traffic mix in percent, changed between edges by the test sequence
	int feed_pct;
	int commit_pct;
	int credit_pct;
	int flush_pct;
	logic flush_req;
	int accepted_count;
	int out_count;
	int phase_start;

	`include "rename_model.svh"

	rename_stage rename_stage_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_rs1(in_rs1),
		.in_rs2(in_rs2),
		.in_rd(in_rd),
		.in_makes_rd(in_makes_rd),
		.in_pc(in_pc),
		.commit_valid(commit_valid),
		.flush(flush),
		.credit_return(credit_return),
		.in_stall(in_stall),
		.out_valid(out_valid),
		.out_rs1_pending(out_rs1_pending),
		.out_rs1_tag(out_rs1_tag),
		.out_rs2_pending(out_rs2_pending),
		.out_rs2_tag(out_rs2_tag),
		.out_rd_slot(out_rd_slot),
		.out_rd_arch(out_rd_arch),
		.out_makes_rd(out_makes_rd),
		.out_pc(out_pc)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected)
			else report_failure($sformatf("mismatch %s: got 0x%h expected 0x%h",
				name, got, expected));
	endtask

	function automatic logic chance_hit(int pct);
		return $urandom_range(99, 0) < pct;
	endfunction

	// mostly low registers so that dependences and x0 show up often
	function automatic arch_reg_t pick_reg();
		if (chance_hit(80)) begin
			return arch_reg_t'($urandom_range(7, 0));
		end
		return arch_reg_t'($urandom_range(31, 0));
	endfunction

	task automatic set_traffic(input int feed, input int commit, input int credit,
			input int flsh);
		feed_pct = feed;
		commit_pct = commit;
		credit_pct = credit;
		flush_pct = flsh;
	endtask

	task automatic wait_accepted(input int target);
		do @(negedge clk); while (accepted_count < target);
	endtask

	// everything accepted has come out, all credits back, ring empty
	task automatic drain();
		set_traffic(0, 100, 100, 0);
		do @(negedge clk);
		while (expect_queue.size() != 0 || credit_count != ISSUE_CREDITS || ring_count != 0);
	endtask

	task automatic flush_now();
		flush_req = 1'b1;
		repeat (2) @(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// an op fired into a flush cycle must not reach the output
	assert property (@(posedge clk) disable iff (reset) flush |=> !out_valid)
		else report_failure($sformatf("mismatch out_valid: got 0x%h expected 0x0 after flush",
			out_valid));

	// model and output check first, then the inputs for the next cycle
	always @(posedge clk) begin
		decoded_inst_t inst;
		renamed_op_t expected;
		if (reset) begin
			in_valid <= 1'b0;
			commit_valid <= 1'b0;
			credit_return <= 1'b0;
			flush <= 1'b0;
		end else begin
			if (out_valid) begin
				assert (expect_queue.size() > 0)
					else report_failure("out_valid seen with no accepted instruction waiting");
				assert (ring_count < NUM_SLOTS)
					else report_failure("op issued while all commit slots were in use");
				inst = expect_queue.pop_front();
				expected = rename_next(inst);
				assert (credit_count >= 0)
					else report_failure("more ops issued than the issue credits allow");
				compare_field("out_rs1_pending", out_rs1_pending, expected.rs1.pending);
				compare_field("out_rs1_tag", out_rs1_tag, expected.rs1.tag);
				compare_field("out_rs2_pending", out_rs2_pending, expected.rs2.pending);
				compare_field("out_rs2_tag", out_rs2_tag, expected.rs2.tag);
				compare_field("out_rd_slot", out_rd_slot, expected.rd_slot);
				compare_field("out_rd_arch", out_rd_arch, expected.rd_arch);
				compare_field("out_makes_rd", out_makes_rd, expected.makes_rd);
				compare_field("out_pc", out_pc, expected.pc);
				out_count++;
			end
			if (credit_return) begin
				credit_count++;
			end
			if (commit_valid && !flush) begin
				retire_oldest();
			end
			if (flush) begin
				clear_state();
			end else if (in_valid && !in_stall) begin
				inst.rs1 = in_rs1;
				inst.rs2 = in_rs2;
				inst.rd = in_rd;
				inst.makes_rd = in_makes_rd;
				inst.pc = in_pc;
				expect_queue.push_back(inst);
				accepted_count++;
			end
			in_valid <= chance_hit(feed_pct);
			in_rs1 <= pick_reg();
			in_rs2 <= pick_reg();
			in_rd <= pick_reg();
			in_makes_rd <= chance_hit(80);
			in_pc <= $urandom;
			commit_valid <= ring_count > 0 && chance_hit(commit_pct);
			credit_return <= credit_count < ISSUE_CREDITS && chance_hit(credit_pct);
			flush <= flush_req || chance_hit(flush_pct);
			flush_req = 1'b0;
		end
	end

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		in_valid = 1'b0;
		in_rs1 = '0;
		in_rs2 = '0;
		in_rd = '0;
		in_makes_rd = 1'b0;
		in_pc = '0;
		commit_valid = 1'b0;
		flush = 1'b0;
		credit_return = 1'b0;
		flush_req = 1'b0;
		accepted_count = 0;
		out_count = 0;
		set_traffic(0, 0, 0, 0);
		clear_state();
		credit_count = ISSUE_CREDITS;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!in_stall && !out_valid)
			else report_failure("in_stall or out_valid high right after reset");

		set_traffic(70, 50, 60, 2);
		wait_accepted(250);

		// no commits, so all 16 slots fill and decode stalls
		set_traffic(100, 0, 100, 0);
		flush_now();
		do @(negedge clk); while (ring_count != NUM_SLOTS);
		repeat (8) begin
			@(negedge clk);
			assert (in_stall && !out_valid)
				else report_failure("commit slots full but decode not stalled or an op issued");
		end
		drain();

		// credits withheld, only the initial credits can be spent
		phase_start = out_count;
		set_traffic(100, 50, 0, 0);
		repeat (40) @(negedge clk);
		compare_field("issued op count", out_count - phase_start, ISSUE_CREDITS);
		assert (in_stall)
			else report_failure("decode not stalled after the issue credits ran out");
		drain();

		set_traffic(70, 50, 60, 2);
		wait_accepted(NUM_INSTS);
		drain();
		$display("Finished with no errors");
		$finish;
	end

	initial begin
		#(NUM_INSTS * 40 * CLK_PERIOD);
		report_failure("watchdog timeout before the test sequence completed");
	end

endmodule

// ==== logic/commit_slot_ring.sv ====
/* in-order commit slot ring, hands out tail slots and retires the head */

`timescale 1ns/1ps

module commit_slot_ring (
	input logic clk,
	input logic reset,
	slot_if.ring slots
);
	import rename_pkg::*;

	slot_t head;
	slot_t tail;
	logic [SLOT_COUNT_W-1:0] count;
	logic do_alloc;
	logic do_retire;

	assign slots.full = count == SLOT_COUNT_W'(NUM_SLOTS);
	assign do_alloc = slots.alloc && !slots.full;
	// commit on an empty ring has nothing to retire
	assign do_retire = slots.retire && count != '0;

	always_ff @(posedge clk) begin
		if (reset || slots.flush) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_alloc) begin
				tail <= tail + 1'b1;
			end
			if (do_retire) begin
				head <= head + 1'b1;
			end
			case ({do_alloc, do_retire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign slots.alloc_slot = tail;
	assign slots.retire_slot = head;

endmodule

// ==== logic/issue_credit.sv ====
/* output register for renamed ops and the issue queue credit counter */

`timescale 1ns/1ps

module issue_credit (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic credit_return,
	renamed_op_if.sink ops,
	output logic out_valid,
	output rename_pkg::renamed_op_t out_op
);
	import rename_pkg::*;

	logic [CREDIT_W-1:0] credits;

	assign ops.credit_ok = credits != '0;

	// one credit per fire, one back per credit_return cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= CREDIT_W'(ISSUE_CREDITS);
		end else begin
			case ({credit_return, ops.fire})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= ops.fire && !flush;
		end
	end

	always_ff @(posedge clk) begin
		if (ops.fire) begin
			out_op <= ops.op;
		end
	end

endmodule

// ==== logic/rename_intake.sv ====
/* single entry holding register in front of the rename map, with decode stall */

`timescale 1ns/1ps

module rename_intake (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic in_valid,
	input rename_pkg::decoded_inst_t in_inst,
	output logic in_stall,
	rename_req_if.source req
);
	import rename_pkg::*;

	logic held_valid;
	decoded_inst_t held_inst;
	logic accept;

	// a slot opens up in the same cycle the map takes the held instruction
	assign in_stall = held_valid && !req.take;
	assign accept = in_valid && !in_stall && !flush;

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			held_valid <= 1'b0;
		end else if (accept) begin
			held_valid <= 1'b1;
		end else if (req.take) begin
			held_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			held_inst <= in_inst;
		end
	end

	assign req.valid = held_valid;
	assign req.inst = held_inst;

endmodule

// ==== logic/rename_map.sv ====
/* architectural register to commit slot map, with lookup, update,
   retire clear and flush */

`timescale 1ns/1ps

module rename_map (
	input logic clk,
	input logic reset,
	input logic commit_valid,
	input logic flush,
	rename_req_if.sink req,
	slot_if.map slots,
	renamed_op_if.source ops
);
	import rename_pkg::*;

	operand_t map_q [NUM_ARCH_REGS];
	logic fire;
	logic retire;
	logic writes_rd;
	operand_t rs1_entry;
	operand_t rs2_entry;
	logic rs1_retiring;
	logic rs2_retiring;
	operand_t rs1_op;
	operand_t rs2_op;

	// pending slot, unless x0 or its writer is retiring right now
	function automatic operand_t resolve(arch_reg_t r, operand_t e, logic retiring);
		operand_t o;
		o.pending = 1'b0;
		o.tag = r;
		if (r != '0 && e.pending && !retiring) begin
			o.pending = 1'b1;
			o.tag = e.tag;
		end
		return o;
	endfunction

	assign fire = req.valid && !slots.full && ops.credit_ok && !flush;
	assign retire = commit_valid && !flush;
	assign writes_rd = fire && req.inst.makes_rd && req.inst.rd != '0;

	// sources see the map before this op's own rd update
	assign rs1_entry = map_q[req.inst.rs1];
	assign rs2_entry = map_q[req.inst.rs2];
	assign rs1_retiring = retire && rs1_entry.tag[SLOT_W-1:0] == slots.retire_slot;
	assign rs2_retiring = retire && rs2_entry.tag[SLOT_W-1:0] == slots.retire_slot;
	assign rs1_op = resolve(req.inst.rs1, rs1_entry, rs1_retiring);
	assign rs2_op = resolve(req.inst.rs2, rs2_entry, rs2_retiring);

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			for (int i = 0; i < NUM_ARCH_REGS; i++) begin
				map_q[i].pending <= 1'b0;
			end
		end else begin
			if (retire) begin
				for (int i = 0; i < NUM_ARCH_REGS; i++) begin
					if (map_q[i].pending && map_q[i].tag[SLOT_W-1:0] == slots.retire_slot) begin
						map_q[i].pending <= 1'b0;
					end
				end
			end
			// a new writer wins over the retire clear of the same entry
			if (writes_rd) begin
				map_q[req.inst.rd] <= '{pending: 1'b1, tag: ARCH_REG_W'(slots.alloc_slot)};
			end
		end
	end

	assign req.take = fire;
	assign slots.alloc = fire;
	assign slots.retire = retire;
	assign slots.flush = flush;
	assign ops.fire = fire;
	assign ops.op = '{
		rs1: rs1_op,
		rs2: rs2_op,
		rd_slot: slots.alloc_slot,
		rd_arch: req.inst.rd,
		makes_rd: req.inst.makes_rd,
		pc: req.inst.pc
	};

endmodule

// ==== logic/rename_pkg.sv ====
/* widths, counts and shared structs of the register rename stage */

package rename_pkg;

	localparam int NUM_ARCH_REGS = 32;
	localparam int ARCH_REG_W = 5;
	// commit slots that can be in flight at once
	localparam int NUM_SLOTS = 16;
	localparam int SLOT_W = 4;
	localparam int SLOT_COUNT_W = 5;
	// issue queue entries free out of reset
	localparam int ISSUE_CREDITS = 4;
	localparam int CREDIT_W = 3;
	localparam int PC_W = 32;

	typedef logic [ARCH_REG_W-1:0] arch_reg_t;
	typedef logic [SLOT_W-1:0] slot_t;

	// tag is a slot when pending, otherwise the architectural register
	typedef struct packed {
		logic pending;
		logic [ARCH_REG_W-1:0] tag;
	} operand_t;

	typedef struct packed {
		arch_reg_t rs1;
		arch_reg_t rs2;
		arch_reg_t rd;
		logic makes_rd;
		logic [PC_W-1:0] pc;
	} decoded_inst_t;

	typedef struct packed {
		operand_t rs1;
		operand_t rs2;
		slot_t rd_slot;
		arch_reg_t rd_arch;
		logic makes_rd;
		logic [PC_W-1:0] pc;
	} renamed_op_t;

endpackage

// ==== logic/rename_req_if.sv ====
/* held decoded instruction passed from intake to the rename map */

`timescale 1ns/1ps

interface rename_req_if;
	import rename_pkg::*;

	logic valid;
	decoded_inst_t inst;
	// high when the map consumes the instruction this cycle
	logic take;

	modport source (
		output valid,
		output inst,
		input take
	);

	modport sink (
		input valid,
		input inst,
		output take
	);

endinterface

// ==== logic/rename_stage.sv ====
/* register rename stage top level, intake, map, slot ring and issue credit */

`timescale 1ns/1ps

module rename_stage (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [rename_pkg::ARCH_REG_W-1:0] in_rs1,
	input logic [rename_pkg::ARCH_REG_W-1:0] in_rs2,
	input logic [rename_pkg::ARCH_REG_W-1:0] in_rd,
	input logic in_makes_rd,
	input logic [rename_pkg::PC_W-1:0] in_pc,
	input logic commit_valid,
	input logic flush,
	input logic credit_return,
	output logic in_stall,
	output logic out_valid,
	output logic out_rs1_pending,
	output logic [rename_pkg::ARCH_REG_W-1:0] out_rs1_tag,
	output logic out_rs2_pending,
	output logic [rename_pkg::ARCH_REG_W-1:0] out_rs2_tag,
	output logic [rename_pkg::SLOT_W-1:0] out_rd_slot,
	output logic [rename_pkg::ARCH_REG_W-1:0] out_rd_arch,
	output logic out_makes_rd,
	output logic [rename_pkg::PC_W-1:0] out_pc
);
	import rename_pkg::*;

	decoded_inst_t in_inst;
	renamed_op_t out_op;

	rename_req_if req_bus ();
	slot_if slot_bus ();
	renamed_op_if op_bus ();

	assign in_inst = '{
		rs1: in_rs1,
		rs2: in_rs2,
		rd: in_rd,
		makes_rd: in_makes_rd,
		pc: in_pc
	};

	rename_intake rename_intake_i (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.in_valid(in_valid),
		.in_inst(in_inst),
		.in_stall(in_stall),
		.req(req_bus.source)
	);

	rename_map rename_map_i (
		.clk(clk),
		.reset(reset),
		.commit_valid(commit_valid),
		.flush(flush),
		.req(req_bus.sink),
		.slots(slot_bus.map),
		.ops(op_bus.source)
	);

	commit_slot_ring commit_slot_ring_i (
		.clk(clk),
		.reset(reset),
		.slots(slot_bus.ring)
	);

	issue_credit issue_credit_i (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.credit_return(credit_return),
		.ops(op_bus.sink),
		.out_valid(out_valid),
		.out_op(out_op)
	);

	assign out_rs1_pending = out_op.rs1.pending;
	assign out_rs1_tag = out_op.rs1.tag;
	assign out_rs2_pending = out_op.rs2.pending;
	assign out_rs2_tag = out_op.rs2.tag;
	assign out_rd_slot = out_op.rd_slot;
	assign out_rd_arch = out_op.rd_arch;
	assign out_makes_rd = out_op.makes_rd;
	assign out_pc = out_op.pc;

endmodule

// ==== logic/renamed_op_if.sv ====
/* renamed op and issue credit state toward the output register */

`timescale 1ns/1ps

interface renamed_op_if;
	import rename_pkg::*;

	logic fire;
	renamed_op_t op;
	// at least one issue queue entry is free
	logic credit_ok;

	modport source (
		output fire,
		output op,
		input credit_ok
	);

	modport sink (
		input fire,
		input op,
		output credit_ok
	);

endinterface

// ==== logic/slot_if.sv ====
/* allocate, retire and flush requests between rename map and slot ring */

`timescale 1ns/1ps

interface slot_if;
	import rename_pkg::*;

	logic alloc;
	logic retire;
	logic flush;
	slot_t alloc_slot;
	// oldest slot still in flight
	slot_t retire_slot;
	logic full;

	modport map (
		output alloc,
		output retire,
		output flush,
		input alloc_slot,
		input retire_slot,
		input full
	);

	modport ring (
		input alloc,
		input retire,
		input flush,
		output alloc_slot,
		output retire_slot,
		output full
	);

endinterface

// ==== tb.f ====
+incdir+dv
logic/rename_pkg.sv
logic/rename_req_if.sv
logic/slot_if.sv
logic/renamed_op_if.sv
logic/rename_intake.sv
logic/commit_slot_ring.sv
logic/rename_map.sv
logic/issue_credit.sv
logic/rename_stage.sv
dv/rename_stage_tb.sv
